// ==== hw/fe_cfg_pkg.sv ====
// shared widths, vector types and fetch block sizes, referenced by scoped name across the frontend
package fe_cfg_pkg;

    // ----------------------------------------
    // basic widths
    // ----------------------------------------

    // byte address as seen by the fetch unit and the back end
    typedef logic [31:0] addr_t;

    // one uncompressed RV32I instruction word
    typedef logic [31:0] instr_t;

    // one AXI beat, slot 0 in the low half
    typedef logic [63:0] block_t;

    // ----------------------------------------
    // fetch block geometry
    // ----------------------------------------

    // instructions per fetch block
    localparam int unsigned NR_SLOTS = 2;

    // pc step for sequential fetch
    localparam int unsigned BLOCK_BYTES = 8;

    // one bit per instruction slot
    typedef logic [NR_SLOTS-1:0] slot_mask_t;

endpackage

// ==== hw/fe_isa_pkg.sv ====
// RV32I opcode constants and control-flow classes used by the instruction scanners
package fe_isa_pkg;

    // ----------------------------------------
    // major opcodes, instr[6:0]
    // ----------------------------------------

    // jump and link, pc relative
    localparam logic [6:0] OPC_JAL = 7'b1101111;

    // jump and link register, target unknown at fetch
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // conditional branches, all six compare flavours
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ----------------------------------------
    // control-flow kind of one slot
    // ----------------------------------------

    // none means anything that falls through to pc + 4
    typedef enum logic [1:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JAL,
        CF_JALR
    } cf_kind_e;

endpackage

// ==== hw/fe_fetch_ctrl.sv ====
// next-pc selection, single-outstanding AXI4-Lite read FSM and fetch block register
`timescale 1ns/1ps

module fe_fetch_ctrl #(
    parameter fe_cfg_pkg::addr_t BOOT_ADDR = 32'h0000_1000
) (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    // back end restart
    input  logic                                           flush_i,
    input  fe_cfg_pkg::addr_t                              flush_pc_i,
    // AXI4-Lite read channel
    output fe_cfg_pkg::addr_t                              araddr_o,
    output logic                                           arvalid_o,
    input  logic                                           arready_i,
    input  fe_cfg_pkg::block_t                             rdata_i,
    input  logic                                           rvalid_i,
    output logic                                           rready_o,
    // queue has space for a whole block
    input  logic                                           room_i,
    // prediction result for the block in scan
    input  logic                                           redirect_i,
    input  fe_cfg_pkg::addr_t                              redirect_pc_i,
    // sliced block towards the scanners
    output logic                                           blk_valid_o,
    output fe_cfg_pkg::instr_t [fe_cfg_pkg::NR_SLOTS-1:0] slot_instr_o,
    output fe_cfg_pkg::addr_t  [fe_cfg_pkg::NR_SLOTS-1:0] slot_pc_o,
    output fe_cfg_pkg::slot_mask_t                         slot_valid_o
);
    localparam int unsigned INSTR_W = $bits(fe_cfg_pkg::instr_t);
    localparam int unsigned OFS_MSB = $clog2(fe_cfg_pkg::BLOCK_BYTES) - 1;
    // clears the offset inside a block
    localparam fe_cfg_pkg::addr_t BLK_MASK = ~fe_cfg_pkg::addr_t'(fe_cfg_pkg::BLOCK_BYTES - 1);

    typedef enum logic [1:0] {
        ST_ADDR,
        ST_DATA,
        ST_SCAN
    } fetch_state_e;

    fetch_state_e       state_q, state_d;
    // architectural fetch pc, may point into slot 1
    fe_cfg_pkg::addr_t  pc_q, pc_d;
    // block address of the request in flight
    fe_cfg_pkg::addr_t  blk_addr_q, blk_addr_d;
    // response in flight belongs to a flushed stream
    logic               drop_q, drop_d;
    // keeps arvalid low until the first cycle out of reset
    logic               started_q;
    fe_cfg_pkg::block_t blk_q;
    logic               ar_fire;
    logic               r_fire;

    // ----------------------------------------
    // AXI handshakes
    // ----------------------------------------

    assign arvalid_o = started_q && (state_q == ST_ADDR);
    assign araddr_o  = blk_addr_q;
    // hold the response off while the queue cannot take a full block
    assign rready_o  = (state_q == ST_DATA) && room_i;
    assign ar_fire   = arvalid_o && arready_i;
    assign r_fire    = rready_o && rvalid_i;

    // a flush kills the block being scanned
    assign blk_valid_o = (state_q == ST_SCAN) && !flush_i;

    // ----------------------------------------
    // next state and next pc
    // ----------------------------------------

    always_comb begin
        state_d    = state_q;
        pc_d       = pc_q;
        blk_addr_d = blk_addr_q;
        drop_d     = drop_q;
        case (state_q)
            ST_ADDR: begin
                // the AR already offered has to finish with its old address
                if (flush_i) drop_d = 1'b1;
                if (ar_fire) state_d = ST_DATA;
            end
            ST_DATA: begin
                if (flush_i) drop_d = 1'b1;
                if (r_fire) begin
                    // stale data is accepted and thrown away
                    drop_d  = 1'b0;
                    state_d = (drop_q || flush_i) ? ST_ADDR : ST_SCAN;
                end
            end
            ST_SCAN: begin
                state_d = ST_ADDR;
                if (redirect_i) begin
                    pc_d = redirect_pc_i;
                end else begin
                    pc_d = blk_addr_q + fe_cfg_pkg::addr_t'(fe_cfg_pkg::BLOCK_BYTES);
                end
            end
            default: state_d = ST_ADDR;
        endcase
        // back end restart wins over everything
        if (flush_i) pc_d = flush_pc_i;
        // new request address is latched only when a fresh AR starts
        if ((state_d == ST_ADDR) && (state_q != ST_ADDR)) blk_addr_d = pc_d & BLK_MASK;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ST_ADDR;
            pc_q       <= BOOT_ADDR;
            blk_addr_q <= BOOT_ADDR & BLK_MASK;
            drop_q     <= 1'b0;
            started_q  <= 1'b0;
        end else begin
            state_q    <= state_d;
            pc_q       <= pc_d;
            blk_addr_q <= blk_addr_d;
            drop_q     <= drop_d;
            started_q  <= 1'b1;
        end
    end

    // block data, only looked at in ST_SCAN
    always_ff @(posedge clk_i) begin
        if (r_fire) blk_q <= rdata_i;
    end

    // ----------------------------------------
    // slot slicing
    // ----------------------------------------

    for (genvar i = 0; i < fe_cfg_pkg::NR_SLOTS; i++) begin : gen_slot
        assign slot_instr_o[i] = blk_q[i*INSTR_W +: INSTR_W];
        assign slot_pc_o[i]    = blk_addr_q + fe_cfg_pkg::addr_t'(i * 4);
        // slots below the entry offset were not asked for
        assign slot_valid_o[i] = (i >= int'(pc_q[OFS_MSB:2]));
    end

endmodule

// ==== hw/fe_instr_scan.sv ====
// combinational decode of one instruction slot into control-flow kind, static prediction and target
`timescale 1ns/1ps

module fe_instr_scan (
    input  fe_cfg_pkg::instr_t    instr_i,
    input  fe_cfg_pkg::addr_t     pc_i,
    output fe_isa_pkg::cf_kind_e  kind_o,
    output logic                  taken_o,
    output fe_cfg_pkg::addr_t     target_o
);
    logic [6:0]        opcode;
    fe_cfg_pkg::addr_t imm_j;
    fe_cfg_pkg::addr_t imm_b;
    fe_cfg_pkg::addr_t imm;

    assign opcode = instr_i[6:0];

    // J-type immediate, sign in bit 31
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    // B-type immediate
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    always_comb begin
        kind_o = fe_isa_pkg::CF_NONE;
        imm    = '0;
        case (opcode)
            fe_isa_pkg::OPC_JAL: begin
                kind_o = fe_isa_pkg::CF_JAL;
                imm    = imm_j;
            end
            fe_isa_pkg::OPC_BRANCH: begin
                kind_o = fe_isa_pkg::CF_BRANCH;
                imm    = imm_b;
            end
            // register target, never predicted
            fe_isa_pkg::OPC_JALR: kind_o = fe_isa_pkg::CF_JALR;
            default: ;
        endcase
    end

    // jal always, backward branches only
    assign taken_o = (kind_o == fe_isa_pkg::CF_JAL) ||
                     ((kind_o == fe_isa_pkg::CF_BRANCH) && imm_b[31]);

    // word aligned, compressed code is not supported
    assign target_o = (pc_i + imm) & ~fe_cfg_pkg::addr_t'(3);

endmodule

// ==== hw/fe_predict_sel.sv ====
// keeps the first predicted-taken slot of a block, masks the slots after it and issues the redirect
`timescale 1ns/1ps

module fe_predict_sel (
    input  logic                                             blk_valid_i,
    input  fe_cfg_pkg::slot_mask_t                           slot_valid_i,
    input  fe_cfg_pkg::instr_t   [fe_cfg_pkg::NR_SLOTS-1:0]  slot_instr_i,
    input  fe_cfg_pkg::addr_t    [fe_cfg_pkg::NR_SLOTS-1:0]  slot_pc_i,
    input  fe_isa_pkg::cf_kind_e [fe_cfg_pkg::NR_SLOTS-1:0]  kind_i,
    input  fe_cfg_pkg::slot_mask_t                           taken_i,
    input  fe_cfg_pkg::addr_t    [fe_cfg_pkg::NR_SLOTS-1:0]  target_i,
    // towards the queue
    output fe_cfg_pkg::slot_mask_t                           push_o,
    output fe_cfg_pkg::instr_t   [fe_cfg_pkg::NR_SLOTS-1:0]  push_instr_o,
    output fe_cfg_pkg::addr_t    [fe_cfg_pkg::NR_SLOTS-1:0]  push_pc_o,
    output fe_cfg_pkg::slot_mask_t                           push_taken_o,
    // towards the pc logic
    output logic                                             redirect_o,
    output fe_cfg_pkg::addr_t                                redirect_pc_o
);
    // taken flag qualified by the kinds that carry a known target
    fe_cfg_pkg::slot_mask_t taken_ok;
    // a lower slot already changed the flow
    logic                   found;

    for (genvar i = 0; i < fe_cfg_pkg::NR_SLOTS; i++) begin : gen_qual
        assign taken_ok[i] = taken_i[i] &&
                             ((kind_i[i] == fe_isa_pkg::CF_JAL) ||
                              (kind_i[i] == fe_isa_pkg::CF_BRANCH));
    end

    // ----------------------------------------
    // lowest taken slot wins
    // ----------------------------------------

    always_comb begin
        push_o        = '0;
        push_taken_o  = '0;
        found         = 1'b0;
        redirect_pc_o = '0;
        for (int i = 0; i < fe_cfg_pkg::NR_SLOTS; i++) begin
            // slots behind the winner are on the wrong path
            if (blk_valid_i && slot_valid_i[i] && !found) begin
                push_o[i]       = 1'b1;
                push_taken_o[i] = taken_ok[i];
                if (taken_ok[i]) begin
                    found         = 1'b1;
                    redirect_pc_o = target_i[i];
                end
            end
        end
    end

    assign redirect_o = found;

    // payload goes to the queue as is, push_o decides what is written
    assign push_instr_o = slot_instr_i;
    assign push_pc_o    = slot_pc_i;

endmodule

// ==== hw/fe_instr_queue.sv ====
// two-write one-read circular FIFO of fetch entries feeding the back end valid/ready port
`timescale 1ns/1ps

module fe_instr_queue #(
    parameter int unsigned QUEUE_DEPTH = 8
) (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic                                           flush_i,
    // write side, up to one entry per slot
    input  fe_cfg_pkg::slot_mask_t                         push_i,
    input  fe_cfg_pkg::instr_t [fe_cfg_pkg::NR_SLOTS-1:0] push_instr_i,
    input  fe_cfg_pkg::addr_t  [fe_cfg_pkg::NR_SLOTS-1:0] push_pc_i,
    input  fe_cfg_pkg::slot_mask_t                         push_taken_i,
    // a whole block fits
    output logic                                           room_o,
    // back end port
    output logic                                           fetch_valid_o,
    input  logic                                           fetch_ready_i,
    output fe_cfg_pkg::instr_t                             fetch_instr_o,
    output fe_cfg_pkg::addr_t                              fetch_pc_o,
    output logic                                           fetch_taken_o
);
    localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    // number of slots written this cycle
    logic [CNT_W-1:0]   n_push;
    // compacted write position of each slot
    logic [PTR_W-1:0]   wr_idx [fe_cfg_pkg::NR_SLOTS];
    logic               pop;

    fe_cfg_pkg::instr_t instr_mem [QUEUE_DEPTH];
    fe_cfg_pkg::addr_t  pc_mem [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] taken_mem;

    // ----------------------------------------
    // write side
    // ----------------------------------------

    // pushed slots land back to back in slot order
    always_comb begin
        n_push = '0;
        for (int i = 0; i < fe_cfg_pkg::NR_SLOTS; i++) begin
            wr_idx[i] = wr_ptr_q + n_push[PTR_W-1:0];
            n_push    = n_push + CNT_W'(push_i[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < fe_cfg_pkg::NR_SLOTS; i++) begin
            if (push_i[i] && !flush_i) begin
                instr_mem[wr_idx[i]] <= push_instr_i[i];
                pc_mem[wr_idx[i]]    <= push_pc_i[i];
                taken_mem[wr_idx[i]] <= push_taken_i[i];
            end
        end
    end

    // ----------------------------------------
    // pointers and fill level
    // ----------------------------------------

    assign pop = fetch_valid_o && fetch_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // everything queued is on the old path
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + n_push[PTR_W-1:0];
            if (pop) rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            count_q  <= count_q + n_push - CNT_W'(pop);
        end
    end

    // ----------------------------------------
    // read side
    // ----------------------------------------

    // head entry is read from storage, stable until popped
    assign fetch_valid_o = (count_q != '0);
    assign fetch_instr_o = instr_mem[rd_ptr_q];
    assign fetch_pc_o    = pc_mem[rd_ptr_q];
    assign fetch_taken_o = taken_mem[rd_ptr_q];

    assign room_o = (count_q <= CNT_W'(QUEUE_DEPTH - fe_cfg_pkg::NR_SLOTS));

endmodule

// ==== hw/frontend_top.sv ====
// RV32I fetch frontend top, AXI4-Lite read manager on one side and back end fetch port on the other
`timescale 1ns/1ps

module frontend_top #(
    parameter fe_cfg_pkg::addr_t BOOT_ADDR   = 32'h0000_1000,
    parameter int unsigned       QUEUE_DEPTH = 8
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    // AXI4-Lite read channel
    output fe_cfg_pkg::addr_t  araddr_o,
    output logic [2:0]         arprot_o,
    output logic               arvalid_o,
    input  logic               arready_i,
    input  fe_cfg_pkg::block_t rdata_i,
    input  logic [1:0]         rresp_i,
    input  logic               rvalid_i,
    output logic               rready_o,
    // back end
    output logic               fetch_valid_o,
    input  logic               fetch_ready_i,
    output fe_cfg_pkg::instr_t fetch_instr_o,
    output fe_cfg_pkg::addr_t  fetch_pc_o,
    output logic               fetch_taken_o,
    input  logic               flush_i,
    input  fe_cfg_pkg::addr_t  flush_pc_i
);
    // fetch ctrl to scanners and selector
    logic                                             blk_valid;
    fe_cfg_pkg::instr_t   [fe_cfg_pkg::NR_SLOTS-1:0]  slot_instr;
    fe_cfg_pkg::addr_t    [fe_cfg_pkg::NR_SLOTS-1:0]  slot_pc;
    fe_cfg_pkg::slot_mask_t                           slot_valid;
    // scanner results
    fe_isa_pkg::cf_kind_e [fe_cfg_pkg::NR_SLOTS-1:0]  slot_kind;
    fe_cfg_pkg::slot_mask_t                           slot_taken;
    fe_cfg_pkg::addr_t    [fe_cfg_pkg::NR_SLOTS-1:0]  slot_target;
    // selector to queue and pc logic
    fe_cfg_pkg::slot_mask_t                           push;
    fe_cfg_pkg::instr_t   [fe_cfg_pkg::NR_SLOTS-1:0]  push_instr;
    fe_cfg_pkg::addr_t    [fe_cfg_pkg::NR_SLOTS-1:0]  push_pc;
    fe_cfg_pkg::slot_mask_t                           push_taken;
    logic                                             redirect;
    fe_cfg_pkg::addr_t                                redirect_pc;
    logic                                             room;

    // no protection attributes on fetch reads
    assign arprot_o = 3'b000;

    fe_fetch_ctrl #(
        .BOOT_ADDR (BOOT_ADDR)
    ) u_fetch_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .flush_pc_i    (flush_pc_i),
        .araddr_o      (araddr_o),
        .arvalid_o     (arvalid_o),
        .arready_i     (arready_i),
        .rdata_i       (rdata_i),
        .rvalid_i      (rvalid_i),
        .rready_o      (rready_o),
        .room_i        (room),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .blk_valid_o   (blk_valid),
        .slot_instr_o  (slot_instr),
        .slot_pc_o     (slot_pc),
        .slot_valid_o  (slot_valid)
    );

    // one scanner per instruction slot
    for (genvar i = 0; i < fe_cfg_pkg::NR_SLOTS; i++) begin : gen_scan
        fe_instr_scan u_scan (
            .instr_i  (slot_instr[i]),
            .pc_i     (slot_pc[i]),
            .kind_o   (slot_kind[i]),
            .taken_o  (slot_taken[i]),
            .target_o (slot_target[i])
        );
    end

    fe_predict_sel u_predict_sel (
        .blk_valid_i   (blk_valid),
        .slot_valid_i  (slot_valid),
        .slot_instr_i  (slot_instr),
        .slot_pc_i     (slot_pc),
        .kind_i        (slot_kind),
        .taken_i       (slot_taken),
        .target_i      (slot_target),
        .push_o        (push),
        .push_instr_o  (push_instr),
        .push_pc_o     (push_pc),
        .push_taken_o  (push_taken),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    fe_instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_instr_queue (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .push_i        (push),
        .push_instr_i  (push_instr),
        .push_pc_i     (push_pc),
        .push_taken_i  (push_taken),
        .room_o        (room),
        .fetch_valid_o (fetch_valid_o),
        .fetch_ready_i (fetch_ready_i),
        .fetch_instr_o (fetch_instr_o),
        .fetch_pc_o    (fetch_pc_o),
        .fetch_taken_o (fetch_taken_o)
    );

endmodule

// ==== bench/frontend_sva.sv ====
// protocol checks bound into the frontend top on its AXI4-Lite read port and back end port
`timescale 1ns/1ps

module frontend_sva (
    input logic               clk_i,
    input logic               rst_ni,
    input fe_cfg_pkg::addr_t  araddr_i,
    input logic               arvalid_i,
    input logic               arready_i,
    input logic [1:0]         rresp_i,
    input logic               rvalid_i,
    input logic               fetch_valid_i,
    input logic               fetch_ready_i,
    input fe_cfg_pkg::instr_t fetch_instr_i,
    input fe_cfg_pkg::addr_t  fetch_pc_i,
    input logic               fetch_taken_i,
    input logic               flush_i
);

    // ----------------------------------------
    // AXI read channel
    // ----------------------------------------

    // request is held until the slave takes it
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else $error("AR request dropped or changed before acceptance");

    // block aligned
    ar_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
        arvalid_i |-> araddr_i[2:0] == 3'b000)
        else $error("AR address not aligned to a fetch block");

    r_okay: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i |-> rresp_i == 2'b00)
        else $error("read response is not OKAY");

    // ----------------------------------------
    // back end port
    // ----------------------------------------

    // a flush may take the head entry away
    fetch_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_valid_i && !fetch_ready_i && !flush_i |=>
            fetch_valid_i && $stable(fetch_pc_i) && $stable(fetch_instr_i) &&
            $stable(fetch_taken_i))
        else $error("fetch entry changed before the back end took it");

endmodule

bind frontend_top frontend_sva u_sva (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .araddr_i      (araddr_o),
    .arvalid_i     (arvalid_o),
    .arready_i     (arready_i),
    .rresp_i       (rresp_i),
    .rvalid_i      (rvalid_i),
    .fetch_valid_i (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .fetch_instr_i (fetch_instr_o),
    .fetch_pc_i    (fetch_pc_o),
    .fetch_taken_i (fetch_taken_o),
    .flush_i       (flush_i)
);

// ==== bench/frontend_tb.sv ====
// testbench for the fetch frontend: random program image, AXI slave, stalling back end, reference
`timescale 1ns/1ps

module frontend_tb;

    localparam fe_cfg_pkg::addr_t BOOT_ADDR   = 32'h0000_1000;
    localparam int unsigned       QUEUE_DEPTH = 8;
    localparam int                N_WORDS     = 256;
    localparam int                N_ENTRIES   = 4000;
    localparam int                CLK_PERIOD  = 40;
    localparam int unsigned       SEED        = 32'h0bcab884;
    // 40 cycles per expected entry
    localparam longint            WATCHDOG_NS = longint'(N_ENTRIES) * 40 * CLK_PERIOD;

    logic clk_i;
    logic rst_ni;
    fe_cfg_pkg::addr_t  araddr;
    logic [2:0]         arprot;
    logic               arvalid;
    logic               arready_i;
    fe_cfg_pkg::block_t rdata_i;
    logic [1:0]         rresp_i;
    logic               rvalid_i;
    logic               rready;
    logic               fetch_valid;
    logic               fetch_ready_i;
    fe_cfg_pkg::instr_t fetch_instr;
    fe_cfg_pkg::addr_t  fetch_pc;
    logic               fetch_taken;
    logic               flush_i;
    fe_cfg_pkg::addr_t  flush_pc_i;

    // program image, plus the flow effect of each word as it was generated
    fe_cfg_pkg::instr_t mem [N_WORDS];
    logic               taken_w [N_WORDS];
    fe_cfg_pkg::addr_t  target_w [N_WORDS];

    // ----------------------------------------
    // reference stream and model state
    // ----------------------------------------
    fe_cfg_pkg::addr_t  exp_pc [$];
    fe_cfg_pkg::instr_t exp_instr [$];
    logic               exp_taken [$];
    fe_cfg_pkg::addr_t  model_pc;

    // AXI slave state, one read in flight
    logic               busy;
    logic               r_next;
    logic               seen_ar;
    int                 delay;
    fe_cfg_pkg::addr_t  rd_addr;

    int          err_count;
    int          n_accepted;
    int          cycle;
    int          next_flush;
    int          stall_left;

    frontend_top #(
        .BOOT_ADDR   (BOOT_ADDR),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .araddr_o      (araddr),
        .arprot_o      (arprot),
        .arvalid_o     (arvalid),
        .arready_i     (arready_i),
        .rdata_i       (rdata_i),
        .rresp_i       (rresp_i),
        .rvalid_i      (rvalid_i),
        .rready_o      (rready),
        .fetch_valid_o (fetch_valid),
        .fetch_ready_i (fetch_ready_i),
        .fetch_instr_o (fetch_instr),
        .fetch_pc_o    (fetch_pc),
        .fetch_taken_o (fetch_taken),
        .flush_i       (flush_i),
        .flush_pc_i    (flush_pc_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        err_count++;
        $display("[FAIL] %s: expected %h, actual %h", name, exp_val, act_val);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_error(input string what);
        err_count++;
        $display("error: %s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // ----------------------------------------
    // instruction encoders
    // ----------------------------------------
    function automatic fe_cfg_pkg::instr_t jal_word(input int ofs, input logic [4:0] rd);
        logic [20:0] imm;
        imm = 21'(ofs);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic fe_cfg_pkg::instr_t branch_word(input int ofs);
        logic [12:0] imm;
        imm = 13'(ofs);
        return {imm[12], imm[10:5], 5'($urandom), 5'($urandom), 3'($urandom),
                imm[4:1], imm[11], 7'b1100011};
    endfunction

    // mostly ALU ops, one in ten each of JAL and JALR, two in ten branches
    task automatic build_program();
        int         sel;
        int         t;
        int         ofs;
        logic [4:0] rd;
        for (int w = 0; w < N_WORDS; w++) begin
            sel = int'($urandom_range(0, 9));
            t   = int'($urandom_range(0, N_WORDS - 1));
            rd  = 5'($urandom);
            if (t == w) t = (t + 1) % N_WORDS;
            // last word loops back so the stream never runs off the image
            if (w == N_WORDS - 1) begin
                sel = 6;
                t   = 0;
            end
            ofs         = (t - w) * 4;
            taken_w[w]  = 1'b0;
            target_w[w] = BOOT_ADDR + 32'(4 * t);
            case (sel)
                6: begin
                    mem[w]     = jal_word(ofs, rd);
                    taken_w[w] = 1'b1;
                end
                7, 8: begin
                    mem[w]     = branch_word(ofs);
                    taken_w[w] = (ofs < 0);
                end
                9: mem[w] = {12'($urandom), 5'($urandom), 3'b000, rd, 7'b1100111};
                default: mem[w] = {12'($urandom), 5'($urandom), 3'($urandom), rd, 7'b0010011};
            endcase
        end
    endtask

    // one fetch block of the reference, from the entry slot up to the first taken slot
    task automatic expect_block();
        fe_cfg_pkg::addr_t blk;
        fe_cfg_pkg::addr_t pc;
        int                w;
        logic              done;
        blk      = model_pc & ~fe_cfg_pkg::addr_t'(7);
        pc       = model_pc;
        done     = 1'b0;
        model_pc = blk + 32'd8;
        while (!done && pc < blk + 32'd8) begin
            w = int'((pc - BOOT_ADDR) >> 2);
            exp_pc.push_back(pc);
            exp_instr.push_back(mem[w]);
            exp_taken.push_back(taken_w[w]);
            if (taken_w[w]) begin
                model_pc = target_w[w];
                done     = 1'b1;
            end
            pc = pc + 32'd4;
        end
    endtask

    task automatic check_entry();
        if (exp_pc.size() == 0) expect_block();
        if (n_accepted == 0) begin
            assert (fetch_pc == BOOT_ADDR)
            else report_mismatch("boot pc", BOOT_ADDR, fetch_pc);
        end
        assert (fetch_pc == exp_pc[0])
        else report_mismatch("stream pc", exp_pc[0], fetch_pc);
        assert (fetch_instr == exp_instr[0])
        else report_mismatch("stream instr", exp_instr[0], fetch_instr);
        assert (fetch_taken == exp_taken[0])
        else report_mismatch("taken flag", 32'(exp_taken[0]), 32'(fetch_taken));
        void'(exp_pc.pop_front());
        void'(exp_instr.pop_front());
        void'(exp_taken.pop_front());
        n_accepted++;
    endtask

    // ----------------------------------------
    // AXI slave, random AR accept and R delay
    // ----------------------------------------
    task automatic drive_axi();
        int w;
        if (r_next) begin
            rvalid_i = 1'b0;
            busy     = 1'b0;
            r_next   = 1'b0;
        end
        if (busy && !rvalid_i) begin
            if (delay == 0) begin
                w = int'((rd_addr - BOOT_ADDR) >> 2);
                assert (rd_addr >= BOOT_ADDR && w <= N_WORDS - 2)
                else report_error("read request outside the program image");
                rdata_i  = {mem[w + 1], mem[w]};
                rvalid_i = 1'b1;
            end else begin
                delay--;
            end
        end
        arready_i = !busy && ($urandom_range(0, 2) != 0);
        // both sides stay put until the coming edge, so the handshake is known now
        if (arvalid && arready_i) begin
            if (!seen_ar) begin
                assert (araddr == BOOT_ADDR)
                else report_mismatch("boot araddr", BOOT_ADDR, araddr);
            end
            // instruction reads carry no protection attributes
            assert (arprot == 3'b000)
            else report_mismatch("arprot", 32'(3'b000), 32'(arprot));
            seen_ar = 1'b1;
            busy    = 1'b1;
            rd_addr = araddr;
            delay   = int'($urandom_range(0, 5));
        end
        if (rvalid_i && rready) r_next = 1'b1;
    endtask

    // ----------------------------------------
    // back end, random stalls and flushes
    // ----------------------------------------
    task automatic drive_backend();
        flush_i = 1'b0;
        if (cycle >= next_flush) begin
            flush_i       = 1'b1;
            flush_pc_i    = BOOT_ADDR + 32'(4 * $urandom_range(0, N_WORDS - 1));
            // nothing leaves the port in the flush cycle
            fetch_ready_i = 1'b0;
            model_pc      = flush_pc_i;
            exp_pc.delete();
            exp_instr.delete();
            exp_taken.delete();
            next_flush    = cycle + int'($urandom_range(200, 400));
        end else begin
            if (stall_left > 0) begin
                fetch_ready_i = 1'b0;
                stall_left--;
            end else begin
                fetch_ready_i = ($urandom_range(0, 3) != 0);
                // now and then a longer stall that fills the queue
                if ($urandom_range(0, 49) == 0) stall_left = int'($urandom_range(5, 30));
            end
            if (fetch_valid && fetch_ready_i) check_entry();
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_ni        = 1'b0;
        arready_i     = 1'b0;
        rdata_i       = '0;
        rresp_i       = 2'b00;
        rvalid_i      = 1'b0;
        fetch_ready_i = 1'b0;
        flush_i       = 1'b0;
        flush_pc_i    = BOOT_ADDR;
        busy          = 1'b0;
        r_next        = 1'b0;
        seen_ar       = 1'b0;
        delay         = 0;
        rd_addr       = '0;
        model_pc      = BOOT_ADDR;
        err_count     = 0;
        n_accepted    = 0;
        cycle         = 0;
        stall_left    = 0;
        next_flush    = int'($urandom_range(200, 400));
        build_program();
        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        while (n_accepted < N_ENTRIES) begin
            @(negedge clk_i);
            cycle++;
            drive_axi();
            drive_backend();
        end
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the back end did not receive all expected entries in time");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== files.f ====
hw/fe_cfg_pkg.sv
hw/fe_isa_pkg.sv
hw/fe_fetch_ctrl.sv
hw/fe_instr_scan.sv
hw/fe_predict_sel.sv
hw/fe_instr_queue.sv
hw/frontend_top.sv
bench/frontend_sva.sv
bench/frontend_tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch frontend testbench

OBJ_DIR := obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module frontend_tb \
		-Mdir $(OBJ_DIR) -o frontend_sim -f files.f

run: compile
	./$(OBJ_DIR)/frontend_sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "CHECKS FAILED" sim.log || [ $$status -ne 0 ]; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) sim.log
